// ==== cmprs_fifo_pkg.sv ====
// buffer geometry localparams, read/write address and data types
package cmprs_fifo_pkg;

    localparam int WADDR_W      = 10;                       // 1024 words of 32 bits
    localparam int RADDR_W      = 9;                        // 512 words of 64 bits
    localparam int WDATA_W      = 32;                       // compressor side word
    localparam int RDATA_W      = 64;                       // memory writer side word
    localparam int CHUNK_WWORDS = 8;                        // 32 bytes in write words
    localparam int CHUNK_RWORDS = 4;                        // 32 bytes in read words

    localparam int CHUNK_WLSB   = $clog2(CHUNK_WWORDS);     // low waddr bits inside a chunk
    localparam int CHUNK_RLSB   = $clog2(CHUNK_RWORDS);     // low raddr bits inside a chunk
    localparam int RAM_DEPTH    = 2 ** RADDR_W;             // rows of the 64-bit view

    typedef logic [WADDR_W-1:0] fifo_waddr_t;               // write word address
    typedef logic [RADDR_W-1:0] fifo_raddr_t;               // read word address
    typedef logic [WDATA_W-1:0] fifo_wdata_t;               // one compressor word
    typedef logic [RDATA_W-1:0] fifo_rdata_t;               // two words, earlier one low

endpackage

// ==== frame_pkg.sv ====
// chunk and frame counter widths, counter types and frame-tracking limits
package frame_pkg;

    localparam int CHUNK_CNT_W    = 8;                      // up to 128 chunks, full buffer
    localparam int FRAME_CNT_W    = 4;                      // frames awaiting confirmation

    // counter saturates here rather than wrapping to zero
    localparam int FRAME_PEND_MAX = (2 ** FRAME_CNT_W) - 1;

    typedef logic [CHUNK_CNT_W-1:0] chunk_count_t;          // complete 32-byte chunks
    typedef logic [FRAME_CNT_W-1:0] frame_count_t;          // frames not yet in memory

endpackage

// ==== fifo_rd_if.sv ====
// read port bundle between the buffer control and the buffer memory, with modports
`timescale 1ns/100ps

interface fifo_rd_if;

    logic                        ren;     // read the array row this cycle
    logic                        regen;   // load output register, ren delayed
    cmprs_fifo_pkg::fifo_raddr_t raddr;   // 64-bit row address
    cmprs_fifo_pkg::fifo_rdata_t rdata;   // registered read data

    modport ctrl (
        output ren,
        output regen,
        output raddr,
        input  rdata
    );

    modport mem (
        input  ren,
        input  regen,
        input  raddr,
        output rdata
    );

endinterface

// ==== out_fifo_wr_addr.sv ====
// write address counter with chunk alignment, chunk-written and end-of-frame pulses
`timescale 1ns/100ps

module out_fifo_wr_addr (
    input  logic                        rclk,
    input  logic                        rst_fifo,
    input  logic                        we,            // one word per cycle
    input  cmprs_fifo_pkg::fifo_wdata_t wdata,
    input  logic                        wa_rst,        // align down to chunk start
    input  logic                        wlast,         // last chunk of frame written
    output logic                        mem_we,
    output cmprs_fifo_pkg::fifo_waddr_t mem_waddr,
    output cmprs_fifo_pkg::fifo_wdata_t mem_wdata,
    output logic                        chunk_written, // 8th word went in last cycle
    output logic                        frame_end      // wlast delayed by one
);
    import cmprs_fifo_pkg::*;

    fifo_waddr_t waddr;                                 // next word goes here
    logic        chunk_last;                            // writing last word of a chunk

    assign chunk_last = we && (&waddr[CHUNK_WLSB-1:0]);

    always_ff @(posedge rclk) begin
        if (rst_fifo) begin
            waddr <= '0;
        end else if (wa_rst) begin
            waddr <= {waddr[WADDR_W-1:CHUNK_WLSB], {CHUNK_WLSB{1'b0}}}; // drop partial words
        end else if (we) begin
            waddr <= waddr + 1'b1;
        end
    end

    always_ff @(posedge rclk) begin
        if (rst_fifo) begin
            chunk_written <= 1'b0;
            frame_end     <= 1'b0;
        end else begin
            chunk_written <= chunk_last;                // single-cycle pulse
            frame_end     <= wlast;
        end
    end

    // memory sees the current address together with the strobe
    assign mem_we    = we;
    assign mem_waddr = waddr;
    assign mem_wdata = wdata;

endmodule

// ==== out_fifo_ram.sv ====
// buffer memory, 32-bit write and 64-bit read with array and output registers
`timescale 1ns/100ps

module out_fifo_ram (
    input  logic                        rclk,
    input  logic                        we,
    input  cmprs_fifo_pkg::fifo_waddr_t waddr,
    input  cmprs_fifo_pkg::fifo_wdata_t wdata,
    fifo_rd_if.mem                      rd
);
    import cmprs_fifo_pkg::*;

    // two banks of 512 words, even write addresses in the low bank
    fifo_wdata_t mem_lo [RAM_DEPTH];
    fifo_wdata_t mem_hi [RAM_DEPTH];
    fifo_rdata_t ram_q;                                 // first read stage

    fifo_raddr_t wrow;                                  // row of the 64-bit view
    logic        whalf;                                 // which half of the row

    assign wrow  = waddr[WADDR_W-1:1];
    assign whalf = waddr[0];

    always_ff @(posedge rclk) begin
        if (we && !whalf) begin
            mem_lo[wrow] <= wdata;                      // earlier word, bits 31:0
        end
        if (we && whalf) begin
            mem_hi[wrow] <= wdata;                      // later word, bits 63:32
        end
    end

    always_ff @(posedge rclk) begin
        if (rd.ren) begin
            ram_q <= {mem_hi[rd.raddr], mem_lo[rd.raddr]};
        end
        if (rd.regen) begin
            rd.rdata <= ram_q;                          // valid 2 cycles after ren
        end
    end

endmodule

// ==== out_fifo_ctrl.sv ====
// read address, delayed read enable, chunk count, chunks left in frame and flush control
`timescale 1ns/100ps

module out_fifo_ctrl (
    input  logic                   rclk,
    input  logic                   rst_fifo,
    input  logic                   chunk_written,  // one more full chunk stored
    input  logic                   frame_end,      // eof pulse
    input  logic                   ren,            // reader takes one 64-bit word
    fifo_rd_if.ctrl                rd,
    output frame_pkg::chunk_count_t fifo_count,    // complete chunks in buffer
    output frame_pkg::chunk_count_t chunks_left,   // chunks of current frame
    output logic                   flush           // drain request
);
    import cmprs_fifo_pkg::*;
    import frame_pkg::*;

    fifo_raddr_t raddr;
    logic        regen;
    logic        chunk_read;                       // 4th word of a chunk read now
    logic        flush_done;                       // nothing more to drain

    assign chunk_read = ren && (&raddr[CHUNK_RLSB-1:0]);

    // last chunk going out this cycle also ends the flush
    assign flush_done = (fifo_count == '0) ||
                        ((fifo_count == chunk_count_t'(1)) && ren);

    // read port toward the memory
    assign rd.ren   = ren;
    assign rd.regen = regen;
    assign rd.raddr = raddr;

    always_ff @(posedge rclk) begin
        if (rst_fifo) begin
            raddr <= '0;
            regen <= 1'b0;
        end else begin
            regen <= ren;                          // output register one cycle later
            if (ren) begin
                raddr <= raddr + 1'b1;
            end
        end
    end

    always_ff @(posedge rclk) begin
        if (rst_fifo) begin
            fifo_count <= '0;
        end else if (chunk_written && !chunk_read) begin
            fifo_count <= fifo_count + 1'b1;
        end else if (!chunk_written && chunk_read) begin
            fifo_count <= fifo_count - 1'b1;
        end                                        // both or neither, hold
    end

    always_ff @(posedge rclk) begin
        if (rst_fifo) begin
            chunks_left <= '0;
        end else if (frame_end) begin
            chunks_left <= fifo_count;             // snapshot at eof
        end else if (chunk_read && (chunks_left != '0)) begin
            chunks_left <= chunks_left - 1'b1;
        end
    end

    always_ff @(posedge rclk) begin
        if (rst_fifo) begin
            flush <= 1'b0;
        end else if (frame_end) begin
            flush <= 1'b1;                         // rises the cycle after eof
        end else if (flush_done) begin
            flush <= 1'b0;
        end
    end

endmodule

// ==== frame_track.sv ====
// counter of frames pending memory confirmation with sticky acknowledge error
`timescale 1ns/100ps

module frame_track (
    input  logic                    rclk,
    input  logic                    rst_fifo,
    input  logic                    frame_end,     // frame handed to the reader
    input  logic                    eof_written,   // frame landed in system memory
    output frame_pkg::frame_count_t frames_pending,
    output logic                    ack_err        // confirmation without a frame
);
    import frame_pkg::*;

    logic none_pending;
    logic at_max;

    assign none_pending = (frames_pending == '0);
    assign at_max       = (frames_pending == frame_count_t'(FRAME_PEND_MAX));

    always_ff @(posedge rclk) begin
        if (rst_fifo) begin
            frames_pending <= '0;
            ack_err        <= 1'b0;
        end else begin
            if (frame_end && !eof_written && !at_max) begin
                frames_pending <= frames_pending + 1'b1;
            end else if (!frame_end && eof_written && !none_pending) begin
                frames_pending <= frames_pending - 1'b1;
            end
            if (eof_written && !frame_end && none_pending) begin
                ack_err <= 1'b1;                   // sticky until reset
            end
        end
    end

endmodule

// ==== cmprs_out_fifo_top.sv ====
// top level of the compressor output buffer, wiring of the blocks with plain ports
`timescale 1ns/100ps

module cmprs_out_fifo_top (
    input  logic                        rclk,
    input  logic                        rst_fifo,
    input  logic                        we,
    input  cmprs_fifo_pkg::fifo_wdata_t wdata,
    input  logic                        wa_rst,
    input  logic                        wlast,
    input  logic                        ren,
    input  logic                        eof_written,
    output cmprs_fifo_pkg::fifo_rdata_t rdata,
    output logic                        eof,            // one cycle per frame
    output logic                        flush,
    output frame_pkg::chunk_count_t     fifo_count,
    output frame_pkg::chunk_count_t     chunks_left,
    output frame_pkg::frame_count_t     frames_pending,
    output logic                        ack_err
);
    import cmprs_fifo_pkg::*;

    logic        mem_we;
    fifo_waddr_t mem_waddr;
    fifo_wdata_t mem_wdata;
    logic        chunk_written;
    logic        frame_end;

    fifo_rd_if rd_if ();                                // ctrl to memory read port

    out_fifo_wr_addr wr_addr_i (
        .rclk          (rclk),
        .rst_fifo      (rst_fifo),
        .we            (we),
        .wdata         (wdata),
        .wa_rst        (wa_rst),
        .wlast         (wlast),
        .mem_we        (mem_we),
        .mem_waddr     (mem_waddr),
        .mem_wdata     (mem_wdata),
        .chunk_written (chunk_written),
        .frame_end     (frame_end)
    );

    out_fifo_ram ram_i (
        .rclk  (rclk),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (mem_wdata),
        .rd    (rd_if.mem)
    );

    out_fifo_ctrl ctrl_i (
        .rclk          (rclk),
        .rst_fifo      (rst_fifo),
        .chunk_written (chunk_written),
        .frame_end     (frame_end),
        .ren           (ren),
        .rd            (rd_if.ctrl),
        .fifo_count    (fifo_count),
        .chunks_left   (chunks_left),
        .flush         (flush)
    );

    frame_track track_i (
        .rclk           (rclk),
        .rst_fifo       (rst_fifo),
        .frame_end      (frame_end),
        .eof_written    (eof_written),
        .frames_pending (frames_pending),
        .ack_err        (ack_err)
    );

    assign rdata = rd_if.rdata;
    assign eof   = frame_end;                           // same pulse as frame_end

endmodule

// ==== tb_cmprs_out_fifo.sv ====
// testbench for the compressor output buffer, command player, word queue model and checks
`timescale 1ns/100ps

module tb_cmprs_out_fifo;
    import cmprs_fifo_pkg::*;
    import frame_pkg::*;

    parameter logic [31:0] SEED = 32'he5b4_89c9;

    localparam int MAX_CMDS = 64;

    logic         rclk;
    logic         rst_fifo;
    logic         we;
    fifo_wdata_t  wdata;
    logic         wa_rst;
    logic         wlast;
    logic         ren;
    logic         eof_written;
    fifo_rdata_t  rdata;
    logic         eof;
    logic         flush;
    chunk_count_t fifo_count;
    chunk_count_t chunks_left;
    frame_count_t frames_pending;
    logic         ack_err;

    logic [103:0] cmd_mem [MAX_CMDS];                  // opcode, data, expected
    int           n_cmds;
    int           cyc       = 0;                       // clock edges since start
    int           cyc_limit = 100000;                  // recomputed from the file
    int           wr_phase  = 0;                       // words into current chunk
    integer       seed;
    fifo_wdata_t  word_q [$];                          // words stored, oldest first
    fifo_rdata_t  rd_exp_q [$];                        // expected read words
    int           rd_due_q [$];                        // cycle each one shows up
    int           eof_due_q [$];                       // cycle each eof pulse is high

    cmprs_out_fifo_top dut0 (
        .rclk(rclk), .rst_fifo(rst_fifo), .we(we), .wdata(wdata), .wa_rst(wa_rst),
        .wlast(wlast), .ren(ren), .eof_written(eof_written), .rdata(rdata), .eof(eof),
        .flush(flush), .fifo_count(fifo_count), .chunks_left(chunks_left),
        .frames_pending(frames_pending), .ack_err(ack_err)
    );

    initial begin
        rclk = 1'b0;
        forever #10 rclk = ~rclk;                      // 20 ns period
    end

    always @(posedge rclk) cyc <= cyc + 1;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_rdata(input fifo_rdata_t got, input fifo_rdata_t exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail at time %0t: %s is %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_count(input chunk_count_t got, input chunk_count_t exp,
                               input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail at time %0t: %s is %0d, expected %0d",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_pending(input frame_count_t got, input frame_count_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail at time %0t: frames_pending is %0d, expected %0d",
                                        $time, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail at time %0t: %s is %b, expected %b",
                                        $time, what, got, exp));
        end
    endtask

    // timeout, delayed read data and eof pulse checks, sampled mid-cycle
    always @(negedge rclk) begin : output_checker
        fifo_rdata_t exp;
        logic        eof_exp;
        if (cyc > cyc_limit) begin
            stop_with_failure("the run went past its cycle limit, the testbench timed out");
        end else begin
            if ((rd_due_q.size() != 0) && (rd_due_q[0] == cyc)) begin
                exp = rd_exp_q.pop_front();
                void'(rd_due_q.pop_front());
                check_rdata(rdata, exp, "rdata");
            end
            eof_exp = (eof_due_q.size() != 0) && (eof_due_q[0] == cyc); // one cycle only
            if (eof_exp) begin
                void'(eof_due_q.pop_front());
            end
            check_flag(eof, eof_exp, "eof");
        end
    end

    task automatic start_cycle();
        @(posedge rclk);
        we          <= 1'b0;                           // strobes idle unless set
        wa_rst      <= 1'b0;
        wlast       <= 1'b0;
        ren         <= 1'b0;
        eof_written <= 1'b0;
    endtask

    task automatic idle_then_sample();
        start_cycle();
        @(negedge rclk);
    endtask

    task automatic write_word(input fifo_wdata_t w);
        start_cycle();
        we    <= 1'b1;
        wdata <= w;
        word_q.push_back(w);
        wr_phase = (wr_phase + 1) % CHUNK_WWORDS;
    endtask

    task automatic realign_write_addr();
        start_cycle();
        wa_rst <= 1'b1;
        repeat (wr_phase) void'(word_q.pop_back());    // partial chunk gets overwritten
        wr_phase = 0;
    endtask

    task automatic read_word(input logic use_file, input fifo_rdata_t file_exp);
        fifo_rdata_t exp;
        if (word_q.size() < 2) begin
            stop_with_failure("the data file reads a word that was never written");
        end else begin
            exp[31:0]  = word_q.pop_front();           // earlier word low
            exp[63:32] = word_q.pop_front();
            if (use_file && (exp !== file_exp)) begin
                stop_with_failure("a read value in the data file disagrees with the writes");
            end else begin
                start_cycle();
                ren <= 1'b1;
                rd_exp_q.push_back(exp);
                rd_due_q.push_back(cyc + 3);           // sampled next edge, out one later
            end
        end
    endtask

    initial begin : player
        int          i;
        fifo_wdata_t w;
        logic [7:0]  op;
        logic [31:0] data;
        logic [63:0] exp;
        seed        = SEED;
        rst_fifo    = 1'b1;
        we          = 1'b0;
        wdata       = '0;
        wa_rst      = 1'b0;
        wlast       = 1'b0;
        ren         = 1'b0;
        eof_written = 1'b0;
        for (i = 0; i < MAX_CMDS; i++) cmd_mem[i] = '0;
        $readmemh("tb_input.dat", cmd_mem);
        n_cmds = 0;
        while ((n_cmds < MAX_CMDS) && (cmd_mem[n_cmds][103:96] != 8'h00)) n_cmds++;
        cyc_limit = 8 * n_cmds + 100;
        repeat (10) @(posedge rclk);
        rst_fifo <= 1'b0;
        for (i = 0; i < n_cmds; i++) begin
            op   = cmd_mem[i][103:96];
            data = cmd_mem[i][95:64];
            exp  = cmd_mem[i][63:0];
            case (op)
                8'h01: write_word(data);
                8'h02: repeat (data) begin
                    w = $random(seed);                 // generated word, queue holds it
                    write_word(w);
                end
                8'h03: realign_write_addr();
                8'h04: begin
                    start_cycle();
                    wlast <= 1'b1;
                    eof_due_q.push_back(cyc + 2);      // sampled next edge, eof right after
                end
                8'h05: read_word(1'b1, exp);
                8'h06: repeat (data) read_word(1'b0, '0);
                8'h07: begin
                    start_cycle();
                    eof_written <= 1'b1;
                end
                8'h08: begin
                    idle_then_sample();
                    check_count(fifo_count, chunk_count_t'(exp), "fifo_count");
                end
                8'h09: begin
                    idle_then_sample();
                    check_count(chunks_left, chunk_count_t'(exp), "chunks_left");
                end
                8'h0a: begin
                    idle_then_sample();
                    check_flag(flush, exp[0], "flush");
                end
                8'h0b: begin
                    idle_then_sample();
                    check_pending(frames_pending, frame_count_t'(exp));
                end
                8'h0c: begin
                    idle_then_sample();
                    check_flag(ack_err, exp[0], "ack_err");
                end
                default: stop_with_failure($sformatf("the data file has unknown opcode %h", op));
            endcase
        end
        start_cycle();
        while ((rd_due_q.size() != 0) || (eof_due_q.size() != 0)) begin
            @(negedge rclk);                           // let the last reads land
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== tb_input.dat ====
// columns: opcode(8) _ data(32) _ expected(64); 01 word, 02 n generated words, 03 wa_rst,
// 04 wlast, 05 read vs file, 06 n reads, 07 eof_written, 08 count, 09 left, 0a flush, 0b pend, 0c err
01_a0000001_0000000000000000
01_a0000002_0000000000000000
01_a0000003_0000000000000000
01_a0000004_0000000000000000
02_00000004_0000000000000000
08_00000000_0000000000000000
08_00000000_0000000000000001
02_00000008_0000000000000000
08_00000000_0000000000000001
08_00000000_0000000000000002
05_00000000_a0000002a0000001
05_00000000_a0000004a0000003
06_00000002_0000000000000000
08_00000000_0000000000000001
06_00000003_0000000000000000
02_00000008_0000000000000000
06_00000001_0000000000000000
08_00000000_0000000000000001
02_00000003_0000000000000000
03_00000000_0000000000000000
02_00000008_0000000000000000
08_00000000_0000000000000001
08_00000000_0000000000000002
04_00000000_0000000000000000
0a_00000000_0000000000000000
0a_00000000_0000000000000001
09_00000000_0000000000000002
0b_00000000_0000000000000001
06_00000004_0000000000000000
09_00000000_0000000000000001
0a_00000000_0000000000000001
06_00000004_0000000000000000
0a_00000000_0000000000000000
08_00000000_0000000000000000
07_00000000_0000000000000000
0b_00000000_0000000000000000
07_00000000_0000000000000000
0c_00000000_0000000000000001
0b_00000000_0000000000000000

// ==== flist.f ====
cmprs_fifo_pkg.sv
frame_pkg.sv
fifo_rd_if.sv
out_fifo_wr_addr.sv
out_fifo_ram.sv
out_fifo_ctrl.sv
frame_track.sv
cmprs_out_fifo_top.sv
tb_cmprs_out_fifo.sv

// ==== Makefile ====
TOP       ?= tb_cmprs_out_fifo
FLIST     ?= flist.f
VERILATOR ?= verilator
SEED      ?= 32'he5b489c9
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -GSEED="$(SEED)" --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
